//--- bench/rob_golden.txt
# test thr1 load1 load2 pc1 pc2 arn1 arn2 prn1 prn2 br1 br2 done1 done2 tag1 tag2 mis1 mis2 tpc1 tpc2
# expected: tag1 tag2 cvalid1 cvalid2 cpc1 cpc2 cthr1_1 cthr1_2 cmis1 cmis2 full1 full2
1 1 1 1 100 104 01 02 21 22 0 0  0 0 0 0 0 0 000 000  0 1 0 0 000 000 0 0 0 0 0 0
1 0 1 1 200 204 03 04 23 24 0 0  0 0 0 0 0 0 000 000  8 9 0 0 000 000 0 0 0 0 0 0
1 1 1 1 108 10c 05 06 25 26 0 0  0 0 0 0 0 0 000 000  2 3 0 0 000 000 0 0 0 0 0 0
1 0 1 1 208 20c 07 08 27 28 0 0  0 0 0 0 0 0 000 000  a b 0 0 000 000 0 0 0 0 0 0
2 0 0 0 000 000 00 00 00 00 0 0  1 1 1 3 0 0 000 000  0 0 0 0 000 000 0 0 0 0 0 0
2 0 0 0 000 000 00 00 00 00 0 0  0 0 0 0 0 0 000 000  0 0 0 0 000 000 0 0 0 0 0 0
2 0 0 0 000 000 00 00 00 00 0 0  1 0 0 0 0 0 000 000  0 0 0 0 000 000 0 0 0 0 0 0
2 0 0 0 000 000 00 00 00 00 0 0  0 0 0 0 0 0 000 000  0 0 1 1 100 104 1 1 0 0 0 0
2 0 0 0 000 000 00 00 00 00 0 0  0 1 0 2 0 0 000 000  0 0 0 0 000 000 0 0 0 0 0 0
2 0 0 0 000 000 00 00 00 00 0 0  0 0 0 0 0 0 000 000  0 0 1 1 108 10c 1 1 0 0 0 0
3 1 1 1 110 114 09 0a 29 2a 0 0  0 0 0 0 0 0 000 000  4 5 0 0 000 000 0 0 0 0 0 0
3 0 0 0 000 000 00 00 00 00 0 0  1 1 4 8 0 0 000 000  0 0 0 0 000 000 0 0 0 0 0 0
3 0 0 0 000 000 00 00 00 00 0 0  0 0 0 0 0 0 000 000  0 0 1 1 110 200 1 0 0 0 0 0
3 0 0 0 000 000 00 00 00 00 0 0  1 1 5 9 0 0 000 000  0 0 0 0 000 000 0 0 0 0 0 0
3 0 0 0 000 000 00 00 00 00 0 0  0 0 0 0 0 0 000 000  0 0 1 1 114 204 1 0 0 0 0 0
3 0 0 0 000 000 00 00 00 00 0 0  1 1 a b 0 0 000 000  0 0 0 0 000 000 0 0 0 0 0 0
3 0 0 0 000 000 00 00 00 00 0 0  0 0 0 0 0 0 000 000  0 0 1 1 208 20c 0 0 0 0 0 0
4 1 1 1 300 304 0b 0c 2b 2c 1 0  0 0 0 0 0 0 000 000  6 7 0 0 000 000 0 0 0 0 0 0
4 1 1 1 308 30c 0d 0e 2d 2e 0 0  0 0 0 0 0 0 000 000  0 1 0 0 000 000 0 0 0 0 0 0
4 0 0 0 000 000 00 00 00 00 0 0  1 1 6 7 1 0 400 000  0 0 0 0 000 000 0 0 0 0 0 0
4 1 1 1 500 504 0f 10 2f 30 0 0  1 1 0 1 0 0 000 000  0 0 1 0 300 000 1 0 1 0 0 0
4 1 1 1 400 404 11 12 31 32 0 0  0 0 0 0 0 0 000 000  7 0 0 0 000 000 0 0 0 0 0 0
4 0 0 0 000 000 00 00 00 00 0 0  1 1 7 0 0 0 000 000  0 0 0 0 000 000 0 0 0 0 0 0
4 0 0 0 000 000 00 00 00 00 0 0  0 0 0 0 0 0 000 000  0 0 1 1 400 404 1 1 0 0 0 0
5 0 1 1 600 604 13 14 33 34 0 0  0 0 0 0 0 0 000 000  c d 0 0 000 000 0 0 0 0 0 0
5 0 1 1 608 60c 15 16 35 36 0 0  0 0 0 0 0 0 000 000  e f 0 0 000 000 0 0 0 0 0 0
5 0 1 1 610 614 17 18 37 38 0 0  0 0 0 0 0 0 000 000  8 9 0 0 000 000 0 0 0 0 0 0
5 0 1 1 618 61c 19 1a 39 3a 0 0  0 0 0 0 0 0 000 000  a b 0 0 000 000 0 0 0 0 0 0
5 0 1 1 620 624 1b 1c 3b 3c 0 0  0 0 0 0 0 0 000 000  0 0 0 0 000 000 0 0 0 0 0 1
5 1 1 1 700 704 1d 1e 3d 3e 0 0  0 0 0 0 0 0 000 000  1 2 0 0 000 000 0 0 0 0 0 1
5 0 0 0 000 000 00 00 00 00 0 0  1 1 c d 0 0 000 000  0 0 0 0 000 000 0 0 0 0 0 1
5 0 0 0 000 000 00 00 00 00 0 0  1 1 e f 0 0 000 000  0 0 1 1 600 604 0 0 0 0 0 1
5 0 0 0 000 000 00 00 00 00 0 0  1 1 8 9 0 0 000 000  0 0 1 1 608 60c 0 0 0 0 0 0
5 0 0 0 000 000 00 00 00 00 0 0  1 1 a b 0 0 000 000  0 0 1 1 610 614 0 0 0 0 0 0
5 0 0 0 000 000 00 00 00 00 0 0  1 1 1 2 0 0 000 000  0 0 1 1 618 61c 0 0 0 0 0 0
5 0 0 0 000 000 00 00 00 00 0 0  0 0 0 0 0 0 000 000  0 0 1 1 700 704 1 1 0 0 0 0
5 0 0 0 000 000 00 00 00 00 0 0  0 0 0 0 0 0 000 000  0 0 0 0 000 000 0 0 0 0 0 0

//--- bench/rob_tb.sv
// run from the project root; the golden vectors assume 8 entries per thread and 32 fields a line
`timescale 1ns/10ps
`default_nettype none
`include "rob_cfg.svh"

module rob_tb;

	localparam int CLOCK_PERIOD = 10;
	localparam int FIELDS = 32;
	localparam int MAX_VECTORS = 256;
	localparam int CYCLES_PER_VECTOR = 20; // watchdog allowance
	localparam int RESET_CYCLES = 3;
	localparam int TAG_W = $clog2(`ROB_ENTRIES) + 1;
	localparam int TAGS = 2 ** TAG_W;

	logic clock;
	logic reset;
	logic is_thread1;
	logic inst1_load;
	logic inst2_load;
	logic [`PC_WIDTH-1:0] inst1_pc;
	logic [`PC_WIDTH-1:0] inst2_pc;
	logic [`ARN_WIDTH-1:0] inst1_arn_dest;
	logic [`ARN_WIDTH-1:0] inst2_arn_dest;
	logic [`PRN_WIDTH-1:0] inst1_prn_dest;
	logic [`PRN_WIDTH-1:0] inst2_prn_dest;
	logic inst1_is_branch;
	logic inst2_is_branch;
	logic fu1_done;
	logic fu2_done;
	logic [TAG_W-1:0] fu1_tag;
	logic [TAG_W-1:0] fu2_tag;
	logic fu1_mispredict;
	logic fu2_mispredict;
	logic [`PC_WIDTH-1:0] fu1_target_pc;
	logic [`PC_WIDTH-1:0] fu2_target_pc;
	logic [TAG_W-1:0] inst1_tag;
	logic [TAG_W-1:0] inst2_tag;
	logic commit1_valid;
	logic commit1_is_thread1;
	logic [`PC_WIDTH-1:0] commit1_pc;
	logic [`PC_WIDTH-1:0] commit1_target_pc;
	logic [`ARN_WIDTH-1:0] commit1_arn_dest;
	logic [`PRN_WIDTH-1:0] commit1_prn_dest;
	logic commit1_is_branch;
	logic commit1_mispredict;
	logic commit2_valid;
	logic commit2_is_thread1;
	logic [`PC_WIDTH-1:0] commit2_pc;
	logic [`PC_WIDTH-1:0] commit2_target_pc;
	logic [`ARN_WIDTH-1:0] commit2_arn_dest;
	logic [`PRN_WIDTH-1:0] commit2_prn_dest;
	logic commit2_is_branch;
	logic commit2_mispredict;
	logic t1_full;
	logic t2_full;

	int seed; // kept for random stimulus later on
	int vec_count;
	int error_count;
	int check_count;
	int cur_vector;
	bit vectors_loaded;

	logic [31:0] vectors [MAX_VECTORS][FIELDS];
	logic [31:0] row [FIELDS]; // fields of the line being parsed

	// dispatched instructions by tag, for the commit fields the golden file does not list
	bit rec_valid [TAGS];
	logic [`PC_WIDTH-1:0] rec_pc [TAGS];
	logic [`ARN_WIDTH-1:0] rec_arn [TAGS];
	logic [`PRN_WIDTH-1:0] rec_prn [TAGS];
	logic rec_branch [TAGS];
	logic [`PC_WIDTH-1:0] rec_target [TAGS]; // last writeback target

	rob_top i_rob_top (.*);

	initial
	begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	function automatic int hex_value(input byte c);
		if (c >= "0" && c <= "9")
			return int'(c) - 48;
		if (c >= "a" && c <= "f")
			return int'(c) - 87;
		if (c >= "A" && c <= "F")
			return int'(c) - 55;
		return -1;
	endfunction

	// splits one text line into hex fields, stopping at a hash
	task automatic parse_fields(input string line, output int n);
		logic [31:0] acc;
		bit in_token;
		bit comment;
		int d;
		n = 0;
		acc = '0;
		in_token = 1'b0;
		comment = 1'b0;
		for (int i = 0; i <= line.len(); i++)
		begin
			d = -1;
			if (i < line.len() && line[i] == "#")
				comment = 1'b1;
			if (i < line.len() && !comment)
				d = hex_value(line[i]);
			if (d >= 0)
			begin
				acc = (acc << 4) | 32'(d);
				in_token = 1'b1;
			end
			else if (in_token)
			begin
				if (n < FIELDS)
					row[n] = acc;
				n++;
				acc = '0;
				in_token = 1'b0;
			end
		end
	endtask

	task automatic read_golden(output bit ok);
		int fd;
		int n;
		int line_no;
		string line;
		fd = $fopen("bench/rob_golden.txt", "r");
		ok = (fd != 0);
		line_no = 0;
		if (ok)
		begin
			while ($fgets(line, fd) != 0)
			begin
				line_no++;
				parse_fields(line, n);
				if (n == FIELDS && vec_count < MAX_VECTORS)
				begin
					for (int k = 0; k < FIELDS; k++)
						vectors[vec_count][k] = row[k];
					vec_count++;
				end
				else if (n != 0)
				begin
					$display("line %0d of the golden file was not used (%0d fields)", line_no, n);
					error_count++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_idle();
		is_thread1 = 1'b0;
		inst1_load = 1'b0;
		inst2_load = 1'b0;
		inst1_pc = '0;
		inst2_pc = '0;
		inst1_arn_dest = '0;
		inst2_arn_dest = '0;
		inst1_prn_dest = '0;
		inst2_prn_dest = '0;
		inst1_is_branch = 1'b0;
		inst2_is_branch = 1'b0;
		fu1_done = 1'b0;
		fu2_done = 1'b0;
		fu1_tag = '0;
		fu2_tag = '0;
		fu1_mispredict = 1'b0;
		fu2_mispredict = 1'b0;
		fu1_target_pc = '0;
		fu2_target_pc = '0;
	endtask

	task automatic drive_vector(input int v);
		is_thread1 = vectors[v][1][0];
		inst1_load = vectors[v][2][0];
		inst2_load = vectors[v][3][0];
		inst1_pc = vectors[v][4][`PC_WIDTH-1:0];
		inst2_pc = vectors[v][5][`PC_WIDTH-1:0];
		inst1_arn_dest = vectors[v][6][`ARN_WIDTH-1:0];
		inst2_arn_dest = vectors[v][7][`ARN_WIDTH-1:0];
		inst1_prn_dest = vectors[v][8][`PRN_WIDTH-1:0];
		inst2_prn_dest = vectors[v][9][`PRN_WIDTH-1:0];
		inst1_is_branch = vectors[v][10][0];
		inst2_is_branch = vectors[v][11][0];
		fu1_done = vectors[v][12][0];
		fu2_done = vectors[v][13][0];
		fu1_tag = vectors[v][14][TAG_W-1:0];
		fu2_tag = vectors[v][15][TAG_W-1:0];
		fu1_mispredict = vectors[v][16][0];
		fu2_mispredict = vectors[v][17][0];
		fu1_target_pc = vectors[v][18][`PC_WIDTH-1:0];
		fu2_target_pc = vectors[v][19][`PC_WIDTH-1:0];
	endtask

	// first is the pc field of the instruction, its other fields follow every second column
	task automatic store_instruction(input int tag, input int v, input int first);
		rec_valid[tag] = 1'b1;
		rec_pc[tag] = vectors[v][first][`PC_WIDTH-1:0];
		rec_arn[tag] = vectors[v][first + 2][`ARN_WIDTH-1:0];
		rec_prn[tag] = vectors[v][first + 4][`PRN_WIDTH-1:0];
		rec_branch[tag] = vectors[v][first + 6][0];
		rec_target[tag] = '0;
	endtask

	// a dropped pair has equal expected tags, an accepted pair never does
	task automatic record_vector(input int v);
		int tag1;
		int tag2;
		tag1 = int'(vectors[v][20][TAG_W-1:0]);
		tag2 = int'(vectors[v][21][TAG_W-1:0]);
		if (vectors[v][2][0] && vectors[v][3][0] && tag1 != tag2)
		begin
			store_instruction(tag1, v, 4);
			store_instruction(tag2, v, 5);
		end
		// port 1 last, it wins on the same tag
		if (vectors[v][13][0])
			rec_target[int'(vectors[v][15][TAG_W-1:0])] = vectors[v][19][`PC_WIDTH-1:0];
		if (vectors[v][12][0])
			rec_target[int'(vectors[v][14][TAG_W-1:0])] = vectors[v][18][`PC_WIDTH-1:0];
	endtask

	// tag of the recorded instruction with this pc, -1 if none
	function automatic int find_pc(input logic [`PC_WIDTH-1:0] pc);
		for (int k = 0; k < TAGS; k++)
			if (rec_valid[k] && rec_pc[k] == pc)
				return k;
		return -1;
	endfunction

	// idle slot shows zeros and the zero register
	task automatic expect_slot(input logic valid, input logic [31:0] pc,
		output logic [31:0] target, output logic [31:0] arn, output logic [31:0] prn,
		output logic [31:0] branch);
		int k;
		target = '0;
		arn = 32'(`ZERO_REG);
		prn = '0;
		branch = '0;
		if (valid)
		begin
			k = find_pc(pc[`PC_WIDTH-1:0]);
			if (k < 0)
			begin
				$display("no dispatched instruction has pc 0x%0h (vector %0d)", pc, cur_vector);
				error_count++;
			end
			else
			begin
				target = 32'(rec_target[k]);
				arn = 32'(rec_arn[k]);
				prn = 32'(rec_prn[k]);
				branch = 32'(rec_branch[k]);
			end
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("** Error: %s = 0x%0h, expected 0x%0h (vector %0d, %0t)",
				name, actual, expected, cur_vector, $time);
		end
	endtask

	// expected values start at field 20
	task automatic check_vector(input int v);
		logic [31:0] target;
		logic [31:0] arn;
		logic [31:0] prn;
		logic [31:0] branch;
		cur_vector = v;
		check_value("inst1_tag", 32'(inst1_tag), vectors[v][20]);
		check_value("inst2_tag", 32'(inst2_tag), vectors[v][21]);
		check_value("commit1_valid", 32'(commit1_valid), vectors[v][22]);
		check_value("commit2_valid", 32'(commit2_valid), vectors[v][23]);
		check_value("commit1_pc", 32'(commit1_pc), vectors[v][24]);
		check_value("commit2_pc", 32'(commit2_pc), vectors[v][25]);
		check_value("commit1_is_thread1", 32'(commit1_is_thread1), vectors[v][26]);
		check_value("commit2_is_thread1", 32'(commit2_is_thread1), vectors[v][27]);
		check_value("commit1_mispredict", 32'(commit1_mispredict), vectors[v][28]);
		check_value("commit2_mispredict", 32'(commit2_mispredict), vectors[v][29]);
		check_value("t1_full", 32'(t1_full), vectors[v][30]);
		check_value("t2_full", 32'(t2_full), vectors[v][31]);
		expect_slot(vectors[v][22][0], vectors[v][24], target, arn, prn, branch);
		check_value("commit1_target_pc", 32'(commit1_target_pc), target);
		check_value("commit1_arn_dest", 32'(commit1_arn_dest), arn);
		check_value("commit1_prn_dest", 32'(commit1_prn_dest), prn);
		check_value("commit1_is_branch", 32'(commit1_is_branch), branch);
		expect_slot(vectors[v][23][0], vectors[v][25], target, arn, prn, branch);
		check_value("commit2_target_pc", 32'(commit2_target_pc), target);
		check_value("commit2_arn_dest", 32'(commit2_arn_dest), arn);
		check_value("commit2_prn_dest", 32'(commit2_prn_dest), prn);
		check_value("commit2_is_branch", 32'(commit2_is_branch), branch);
	endtask

	task automatic print_test_result(input int test, input int vectors_run, input int errors);
		$display("test %0d finished: %0d vectors, %0d errors", test, vectors_run, errors);
	endtask

	initial
	begin
		bit file_ok;
		bit setup_failed;
		int prev_test;
		int test_errors;
		int test_vectors;
		int test_count;
		seed = 66;
		vec_count = 0;
		error_count = 0;
		check_count = 0;
		cur_vector = 0;
		vectors_loaded = 1'b0;
		setup_failed = 1'b0;
		test_count = 0;
		reset = 1'b1;
		drive_idle();
		read_golden(file_ok);
		vectors_loaded = 1'b1;
		if (!file_ok)
		begin
			$display("cannot open the golden file bench/rob_golden.txt");
			setup_failed = 1'b1;
		end
		else if (vec_count == 0)
		begin
			$display("the golden file bench/rob_golden.txt holds no vectors");
			setup_failed = 1'b1;
		end
		else
		begin
			repeat (RESET_CYCLES) @(posedge clock);
			prev_test = int'(vectors[0][0]);
			test_errors = error_count;
			test_vectors = 0;
			for (int v = 0; v < vec_count; v++)
			begin
				if (int'(vectors[v][0]) != prev_test)
				begin
					print_test_result(prev_test, test_vectors, error_count - test_errors);
					test_count++;
					prev_test = int'(vectors[v][0]);
					test_errors = error_count;
					test_vectors = 0;
				end
				#1;
				reset = 1'b0;
				drive_vector(v);
				#(CLOCK_PERIOD - 2); // sample just before the next edge
				check_vector(v);
				record_vector(v);
				test_vectors++;
				@(posedge clock);
			end
			print_test_result(prev_test, test_vectors, error_count - test_errors);
			test_count++;
		end
		$display("%0d tests, %0d vectors, %0d checks, %0d errors",
			test_count, vec_count, check_count, error_count);
		if (error_count == 0 && !setup_failed)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// watchdog sized from the vector count
	initial
	begin
		wait (vectors_loaded);
		#((vec_count + RESET_CYCLES) * CYCLES_PER_VECTOR * CLOCK_PERIOD);
		$display("watchdog expired before all %0d vectors were run", vec_count);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/rob_bank_if.sv
// one instance per thread; no clock inside, all strobes are sampled by the modules
`timescale 1ns/10ps
`default_nettype none

interface rob_bank_if;

	// pair write from dispatch
	logic write_en;
	rob_entry_pkg::rob_ptr_t write_idx;
	rob_entry_pkg::rob_entry_t write_entry1;
	rob_entry_pkg::rob_entry_t write_entry2;

	// stored entries at head and head plus one
	rob_entry_pkg::rob_entry_t head_entry;
	rob_entry_pkg::rob_entry_t next_entry;

	logic [1:0] retire_count; // 0 to 2 entries leave this cycle

	rob_entry_pkg::rob_ptr_t head;
	rob_entry_pkg::rob_count_t count;

	modport bank (
		output head_entry,
		output next_entry,
		input write_en,
		input write_idx,
		input write_entry1,
		input write_entry2,
		input retire_count,
		input head
	);

	modport pointers (
		output write_en,
		output write_idx,
		output write_entry1,
		output write_entry2,
		output head,
		output count,
		input retire_count
	);

	modport commit (
		input head_entry,
		input next_entry,
		input count,
		output retire_count
	);

endinterface

`default_nettype wire

//--- hdl/rob_commit_pkg.sv
// decision types for one cycle of dispatch and retirement
`default_nettype none

package rob_commit_pkg;

	// how many entries leave this cycle and from which thread
	typedef enum logic [2:0] {
		retire_none,
		retire_t1_one,
		retire_t1_two,
		retire_t2_one,
		retire_t2_two,
		retire_t1_then_t2 // thread 1 head on slot 1, thread 2 head on slot 2
	} retire_e;

	// where the offered pair goes
	typedef enum logic [1:0] {
		disp_none,
		disp_t1,
		disp_t2,
		disp_flushed // a mispredict retires, the pair is dropped
	} dispatch_e;

endpackage

`default_nettype wire

//--- hdl/rob_commit_select.sv
// thread 1 always gets first pick; a mispredicted branch is never followed by its own thread
`timescale 1ns/10ps
`default_nettype none
`include "rob_cfg.svh"

module rob_commit_select (
	rob_bank_if.commit t1_bank,
	rob_bank_if.commit t2_bank,
	output rob_entry_pkg::commit_slot_t commit1,
	output rob_entry_pkg::commit_slot_t commit2,
	output logic flush_t1,
	output logic flush_t2
);

	rob_commit_pkg::retire_e retire;

	logic t1_head_ok;
	logic t1_next_ok;
	logic t1_head_mis;
	logic t2_head_ok;
	logic t2_next_ok;
	logic t2_head_mis;

	function automatic rob_entry_pkg::commit_slot_t idle_slot();
		rob_entry_pkg::commit_slot_t s;
		s = '0;
		s.arn_dest = `ARN_WIDTH'(`ZERO_REG);
		return s;
	endfunction

	function automatic rob_entry_pkg::commit_slot_t take(
		input rob_entry_pkg::rob_entry_t e,
		input rob_entry_pkg::thread_e t
	);
		rob_entry_pkg::commit_slot_t s;
		s.valid = 1'b1;
		s.thread = t;
		s.pc = e.pc;
		s.target_pc = e.target_pc;
		s.arn_dest = e.arn_dest;
		s.prn_dest = e.prn_dest;
		s.is_branch = e.is_branch;
		s.mispredict = e.mispredict;
		return s;
	endfunction

	function automatic logic is_flush(
		input rob_entry_pkg::commit_slot_t s,
		input rob_entry_pkg::thread_e t
	);
		return s.valid && (s.thread == t) && s.is_branch && s.mispredict;
	endfunction

	// occupied and executed
	assign t1_head_ok = (t1_bank.count != '0) && t1_bank.head_entry.executed;
	assign t1_next_ok = (t1_bank.count > rob_entry_pkg::rob_count_t'(1))
		&& t1_bank.next_entry.executed;
	assign t1_head_mis = t1_bank.head_entry.is_branch && t1_bank.head_entry.mispredict;

	assign t2_head_ok = (t2_bank.count != '0) && t2_bank.head_entry.executed;
	assign t2_next_ok = (t2_bank.count > rob_entry_pkg::rob_count_t'(1))
		&& t2_bank.next_entry.executed;
	assign t2_head_mis = t2_bank.head_entry.is_branch && t2_bank.head_entry.mispredict;

	always_comb
	begin
		retire = rob_commit_pkg::retire_none;
		if (t1_head_ok)
		begin
			if (t1_next_ok && !t1_head_mis)
				retire = rob_commit_pkg::retire_t1_two;
			else if (t2_head_ok)
				retire = rob_commit_pkg::retire_t1_then_t2; // fill slot 2 from the other thread
			else
				retire = rob_commit_pkg::retire_t1_one;
		end
		else if (t2_head_ok)
		begin
			if (t2_next_ok && !t2_head_mis)
				retire = rob_commit_pkg::retire_t2_two;
			else
				retire = rob_commit_pkg::retire_t2_one;
		end
	end

	always_comb
	begin
		commit1 = idle_slot();
		commit2 = idle_slot();
		t1_bank.retire_count = 2'd0;
		t2_bank.retire_count = 2'd0;
		case (retire)
			rob_commit_pkg::retire_t1_one:
			begin
				commit1 = take(t1_bank.head_entry, rob_entry_pkg::thread_1);
				t1_bank.retire_count = 2'd1;
			end
			rob_commit_pkg::retire_t1_two:
			begin
				commit1 = take(t1_bank.head_entry, rob_entry_pkg::thread_1);
				commit2 = take(t1_bank.next_entry, rob_entry_pkg::thread_1);
				t1_bank.retire_count = 2'd2;
			end
			rob_commit_pkg::retire_t2_one:
			begin
				commit1 = take(t2_bank.head_entry, rob_entry_pkg::thread_2);
				t2_bank.retire_count = 2'd1;
			end
			rob_commit_pkg::retire_t2_two:
			begin
				commit1 = take(t2_bank.head_entry, rob_entry_pkg::thread_2);
				commit2 = take(t2_bank.next_entry, rob_entry_pkg::thread_2);
				t2_bank.retire_count = 2'd2;
			end
			rob_commit_pkg::retire_t1_then_t2:
			begin
				commit1 = take(t1_bank.head_entry, rob_entry_pkg::thread_1);
				commit2 = take(t2_bank.head_entry, rob_entry_pkg::thread_2);
				t1_bank.retire_count = 2'd1;
				t2_bank.retire_count = 2'd1;
			end
			default: ;
		endcase
	end

	// within one thread only the oldest valid slot can carry the mispredict
	assign flush_t1 = is_flush(commit1, rob_entry_pkg::thread_1)
		|| is_flush(commit2, rob_entry_pkg::thread_1);
	assign flush_t2 = is_flush(commit1, rob_entry_pkg::thread_2)
		|| is_flush(commit2, rob_entry_pkg::thread_2);

endmodule

`default_nettype wire

//--- hdl/rob_entry_bank.sv
// one thread's entries; a writeback to an entry that is not occupied is not filtered here
`timescale 1ns/10ps
`default_nettype none
`include "rob_cfg.svh"

module rob_entry_bank (
	input logic clock,
	input logic reset,
	input rob_entry_pkg::thread_e own_thread,
	rob_bank_if.bank bank,
	input logic fu1_done,
	input logic fu2_done,
	input rob_entry_pkg::rob_tag_t fu1_tag,
	input rob_entry_pkg::rob_tag_t fu2_tag,
	input logic fu1_mispredict,
	input logic fu2_mispredict,
	input logic [`PC_WIDTH-1:0] fu1_target_pc,
	input logic [`PC_WIDTH-1:0] fu2_target_pc
);

	rob_entry_pkg::rob_entry_t entries [`ROB_ENTRIES];

	logic fu1_hit;
	logic fu2_hit;

	// writebacks are broadcast to both banks, keep only our own thread
	assign fu1_hit = fu1_done && (fu1_tag.thread == own_thread);
	assign fu2_hit = fu2_done && (fu2_tag.thread == own_thread);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < `ROB_ENTRIES; i++)
				entries[i].executed <= 1'b0;
		end
		else
		begin
			// retired slots must not look finished when the tail wraps onto them
			if (bank.retire_count != 2'd0)
				entries[bank.head].executed <= 1'b0;
			if (bank.retire_count == 2'd2)
				entries[bank.head + 1'b1].executed <= 1'b0;

			if (bank.write_en)
			begin
				entries[bank.write_idx] <= bank.write_entry1;
				entries[bank.write_idx + 1'b1] <= bank.write_entry2;
				entries[bank.write_idx].executed <= 1'b0;
				entries[bank.write_idx + 1'b1].executed <= 1'b0;
				entries[bank.write_idx].mispredict <= 1'b0;
				entries[bank.write_idx + 1'b1].mispredict <= 1'b0;
			end

			// port 2 first so that port 1 overrides it on the same index
			if (fu2_hit)
			begin
				entries[fu2_tag.idx].executed <= 1'b1;
				entries[fu2_tag.idx].mispredict <= fu2_mispredict;
				entries[fu2_tag.idx].target_pc <= fu2_target_pc;
			end
			if (fu1_hit)
			begin
				entries[fu1_tag.idx].executed <= 1'b1;
				entries[fu1_tag.idx].mispredict <= fu1_mispredict;
				entries[fu1_tag.idx].target_pc <= fu1_target_pc;
			end
		end
	end

	assign bank.head_entry = entries[bank.head];
	assign bank.next_entry = entries[bank.head + 1'b1]; // wraps with the pointer width

endmodule

`default_nettype wire

//--- hdl/rob_entry_pkg.sv
// entry, tag and commit slot types; every width follows rob_cfg.svh
`default_nettype none
`include "rob_cfg.svh"

package rob_entry_pkg;

	localparam int PTR_WIDTH = $clog2(`ROB_ENTRIES);

	typedef logic [PTR_WIDTH-1:0] rob_ptr_t; // index inside one thread bank
	typedef logic [PTR_WIDTH:0] rob_count_t; // occupancy, 0 up to ROB_ENTRIES

	typedef enum logic {
		thread_1 = 1'b0,
		thread_2 = 1'b1
	} thread_e;

	// tag given to the reservation stations, thread bit on top
	typedef struct packed {
		thread_e thread;
		rob_ptr_t idx;
	} rob_tag_t;

	typedef struct packed {
		logic [`PC_WIDTH-1:0] pc;
		logic [`ARN_WIDTH-1:0] arn_dest;
		logic [`PRN_WIDTH-1:0] prn_dest;
		logic is_branch;
		logic executed; // set by a function unit writeback
		logic mispredict;
		logic [`PC_WIDTH-1:0] target_pc;
	} rob_entry_t;

	typedef struct packed {
		logic valid;
		thread_e thread;
		logic [`PC_WIDTH-1:0] pc;
		logic [`PC_WIDTH-1:0] target_pc;
		logic [`ARN_WIDTH-1:0] arn_dest;
		logic [`PRN_WIDTH-1:0] prn_dest;
		logic is_branch;
		logic mispredict;
	} commit_slot_t;

endpackage

`default_nettype wire

//--- hdl/rob_pointers.sv
// a pair offered to a full thread is dropped, not held; the supplier watches the full flags
`timescale 1ns/10ps
`default_nettype none
`include "rob_cfg.svh"

module rob_pointers (
	input logic clock,
	input logic reset,
	input logic is_thread1,
	input logic inst1_load,
	input logic inst2_load,
	input rob_entry_pkg::rob_entry_t new_entry1,
	input rob_entry_pkg::rob_entry_t new_entry2,
	input logic flush_t1,
	input logic flush_t2,
	rob_bank_if.pointers t1_bank,
	rob_bank_if.pointers t2_bank,
	output rob_entry_pkg::rob_tag_t inst1_tag,
	output rob_entry_pkg::rob_tag_t inst2_tag,
	output logic t1_full,
	output logic t2_full
);

	// index 0 is thread 1, index 1 is thread 2
	rob_entry_pkg::rob_ptr_t head [2];
	rob_entry_pkg::rob_ptr_t tail [2];
	rob_entry_pkg::rob_count_t count [2];
	logic [1:0] retire [2];
	logic flush [2];
	logic full [2];
	logic place [2];

	rob_commit_pkg::dispatch_e disp;

	assign retire[0] = t1_bank.retire_count;
	assign retire[1] = t2_bank.retire_count;
	assign flush[0] = flush_t1;
	assign flush[1] = flush_t2;

	always_comb
	begin
		// fewer than two free entries
		for (int i = 0; i < 2; i++)
			full[i] = count[i] > rob_entry_pkg::rob_count_t'(`ROB_ENTRIES - 2);
	end

	assign t1_full = full[0];
	assign t2_full = full[1];

	always_comb
	begin
		disp = rob_commit_pkg::disp_none;
		if (flush_t1 || flush_t2)
			disp = rob_commit_pkg::disp_flushed;
		else if (inst1_load && inst2_load)
		begin
			if (is_thread1 && !full[0])
				disp = rob_commit_pkg::disp_t1;
			else if (!is_thread1 && !full[1])
				disp = rob_commit_pkg::disp_t2;
		end
	end

	assign place[0] = (disp == rob_commit_pkg::disp_t1);
	assign place[1] = (disp == rob_commit_pkg::disp_t2);

	// tags are valid in the load cycle, zero otherwise
	always_comb
	begin
		inst1_tag = '0;
		inst2_tag = '0;
		if (place[0])
		begin
			inst1_tag = '{thread: rob_entry_pkg::thread_1, idx: tail[0]};
			inst2_tag = '{thread: rob_entry_pkg::thread_1, idx: tail[0] + 1'b1};
		end
		else if (place[1])
		begin
			inst1_tag = '{thread: rob_entry_pkg::thread_2, idx: tail[1]};
			inst2_tag = '{thread: rob_entry_pkg::thread_2, idx: tail[1] + 1'b1};
		end
	end

	assign t1_bank.write_en = place[0];
	assign t1_bank.write_idx = tail[0];
	assign t1_bank.write_entry1 = new_entry1;
	assign t1_bank.write_entry2 = new_entry2;
	assign t1_bank.head = head[0];
	assign t1_bank.count = count[0];

	assign t2_bank.write_en = place[1];
	assign t2_bank.write_idx = tail[1];
	assign t2_bank.write_entry1 = new_entry1;
	assign t2_bank.write_entry2 = new_entry2;
	assign t2_bank.head = head[1];
	assign t2_bank.count = count[1];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < 2; i++)
			begin
				head[i] <= '0;
				tail[i] <= '0;
				count[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < 2; i++)
			begin
				head[i] <= head[i] + rob_entry_pkg::rob_ptr_t'(retire[i]);
				if (flush[i])
				begin
					// everything younger than the branch is gone
					tail[i] <= head[i] + rob_entry_pkg::rob_ptr_t'(retire[i]);
					count[i] <= '0;
				end
				else if (place[i])
				begin
					tail[i] <= tail[i] + rob_entry_pkg::rob_ptr_t'(2);
					count[i] <= count[i] - rob_entry_pkg::rob_count_t'(retire[i])
						+ rob_entry_pkg::rob_count_t'(2);
				end
				else
					count[i] <= count[i] - rob_entry_pkg::rob_count_t'(retire[i]);
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/rob_top.sv
// flat entry and slot vectors below follow the field order of rob_entry_pkg, keep them in step
`timescale 1ns/10ps
`default_nettype none
`include "rob_cfg.svh"

module rob_top (
	input logic clock,
	input logic reset,
	input logic is_thread1,
	input logic inst1_load,
	input logic inst2_load,
	input logic [`PC_WIDTH-1:0] inst1_pc,
	input logic [`PC_WIDTH-1:0] inst2_pc,
	input logic [`ARN_WIDTH-1:0] inst1_arn_dest,
	input logic [`ARN_WIDTH-1:0] inst2_arn_dest,
	input logic [`PRN_WIDTH-1:0] inst1_prn_dest,
	input logic [`PRN_WIDTH-1:0] inst2_prn_dest,
	input logic inst1_is_branch,
	input logic inst2_is_branch,
	input logic fu1_done,
	input logic fu2_done,
	input logic [$clog2(`ROB_ENTRIES):0] fu1_tag,
	input logic [$clog2(`ROB_ENTRIES):0] fu2_tag,
	input logic fu1_mispredict,
	input logic fu2_mispredict,
	input logic [`PC_WIDTH-1:0] fu1_target_pc,
	input logic [`PC_WIDTH-1:0] fu2_target_pc,
	output logic [$clog2(`ROB_ENTRIES):0] inst1_tag,
	output logic [$clog2(`ROB_ENTRIES):0] inst2_tag,
	output logic commit1_valid,
	output logic commit1_is_thread1,
	output logic [`PC_WIDTH-1:0] commit1_pc,
	output logic [`PC_WIDTH-1:0] commit1_target_pc,
	output logic [`ARN_WIDTH-1:0] commit1_arn_dest,
	output logic [`PRN_WIDTH-1:0] commit1_prn_dest,
	output logic commit1_is_branch,
	output logic commit1_mispredict,
	output logic commit2_valid,
	output logic commit2_is_thread1,
	output logic [`PC_WIDTH-1:0] commit2_pc,
	output logic [`PC_WIDTH-1:0] commit2_target_pc,
	output logic [`ARN_WIDTH-1:0] commit2_arn_dest,
	output logic [`PRN_WIDTH-1:0] commit2_prn_dest,
	output logic commit2_is_branch,
	output logic commit2_mispredict,
	output logic t1_full,
	output logic t2_full
);

	localparam int ENTRY_W = 2 * `PC_WIDTH + `ARN_WIDTH + `PRN_WIDTH + 3;
	localparam int SLOT_W = 2 * `PC_WIDTH + `ARN_WIDTH + `PRN_WIDTH + 4;

	logic [ENTRY_W-1:0] new_entry1;
	logic [ENTRY_W-1:0] new_entry2;
	logic [SLOT_W-1:0] commit1_slot;
	logic [SLOT_W-1:0] commit2_slot;
	logic commit1_thread; // 1 means thread 2
	logic commit2_thread;
	logic flush_t1;
	logic flush_t2;

	rob_bank_if t1_if ();
	rob_bank_if t2_if ();

	// executed, mispredict and target pc start cleared
	assign new_entry1 = {inst1_pc, inst1_arn_dest, inst1_prn_dest, inst1_is_branch,
		2'b00, {`PC_WIDTH{1'b0}}};
	assign new_entry2 = {inst2_pc, inst2_arn_dest, inst2_prn_dest, inst2_is_branch,
		2'b00, {`PC_WIDTH{1'b0}}};

	rob_pointers i_rob_pointers (
		.clock(clock),
		.reset(reset),
		.is_thread1(is_thread1),
		.inst1_load(inst1_load),
		.inst2_load(inst2_load),
		.new_entry1(new_entry1),
		.new_entry2(new_entry2),
		.flush_t1(flush_t1),
		.flush_t2(flush_t2),
		.t1_bank(t1_if.pointers),
		.t2_bank(t2_if.pointers),
		.inst1_tag(inst1_tag),
		.inst2_tag(inst2_tag),
		.t1_full(t1_full),
		.t2_full(t2_full)
	);

	rob_entry_bank i_t1_bank (
		.clock(clock),
		.reset(reset),
		.own_thread(rob_entry_pkg::thread_1),
		.bank(t1_if.bank),
		.fu1_done(fu1_done),
		.fu2_done(fu2_done),
		.fu1_tag(fu1_tag),
		.fu2_tag(fu2_tag),
		.fu1_mispredict(fu1_mispredict),
		.fu2_mispredict(fu2_mispredict),
		.fu1_target_pc(fu1_target_pc),
		.fu2_target_pc(fu2_target_pc)
	);

	rob_entry_bank i_t2_bank (
		.clock(clock),
		.reset(reset),
		.own_thread(rob_entry_pkg::thread_2),
		.bank(t2_if.bank),
		.fu1_done(fu1_done),
		.fu2_done(fu2_done),
		.fu1_tag(fu1_tag),
		.fu2_tag(fu2_tag),
		.fu1_mispredict(fu1_mispredict),
		.fu2_mispredict(fu2_mispredict),
		.fu1_target_pc(fu1_target_pc),
		.fu2_target_pc(fu2_target_pc)
	);

	rob_commit_select i_rob_commit_select (
		.t1_bank(t1_if.commit),
		.t2_bank(t2_if.commit),
		.commit1(commit1_slot),
		.commit2(commit2_slot),
		.flush_t1(flush_t1),
		.flush_t2(flush_t2)
	);

	assign {commit1_valid, commit1_thread, commit1_pc, commit1_target_pc, commit1_arn_dest,
		commit1_prn_dest, commit1_is_branch, commit1_mispredict} = commit1_slot;
	assign {commit2_valid, commit2_thread, commit2_pc, commit2_target_pc, commit2_arn_dest,
		commit2_prn_dest, commit2_is_branch, commit2_mispredict} = commit2_slot;

	// an idle slot reports neither thread
	assign commit1_is_thread1 = commit1_valid & ~commit1_thread;
	assign commit2_is_thread1 = commit2_valid & ~commit2_thread;

endmodule

`default_nettype wire

//--- include/rob_cfg.svh
// ROB_ENTRIES must be a power of two and at least 4, since a thread takes its instructions in pairs
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// entries per thread bank
`define ROB_ENTRIES 8

`define PC_WIDTH 32
`define ARN_WIDTH 5 // architected register number
`define PRN_WIDTH 6 // physical register number

// arn_dest shown on an idle commit slot, so the rename table sees a harmless write
`define ZERO_REG 31

`endif

//--- list.f
+incdir+include
hdl/rob_entry_pkg.sv
hdl/rob_commit_pkg.sv
hdl/rob_bank_if.sv
hdl/rob_entry_bank.sv
hdl/rob_pointers.sv
hdl/rob_commit_select.sv
hdl/rob_top.sv
bench/rob_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the reorder buffer testbench with Verilator and run it from the project root.
# Exit status is 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module rob_tb -f list.f -o rob_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/rob_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
	exit 0
else
	echo "pass line not found in simulation output"
	exit 1
fi
